// File: bench/tb_ddl_tasks.svh
`ifndef TB_DDL_TASKS_SVH
`define TB_DDL_TASKS_SVH

// Compare one value and count the result
task automatic check_value(string what, logic [31:0] exp, logic [31:0] act);
  checks++;
  assert (act === exp) else begin
    errors++;
    $display("CHECK FAILED in %s: %s expected %0h, actual %0h", test_name, what, exp, act);
  end
endtask

// Condition that has no value to compare
task automatic expect_true(bit ok, string msg);
  checks++;
  assert (ok) else begin
    errors++;
    $display("Error in %s: %s", test_name, msg);
  end
endtask

// Hold-off delay of a command, given the command accepted before it
function automatic int cmd_delay(ddl_cmd_e cmd, bit ap, ddl_cmd_e prev);
  case (cmd)
    CMD_ACT:  return `DDL_T_RCD;
    CMD_PRE:  return `DDL_T_RP;
    CMD_REF:  return `DDL_T_RFC;
    CMD_MRS:  return `DDL_T_MRD;
    CMD_ZQCL: return `DDL_T_ZQINIT;
    CMD_RD: begin
      if (ap) return `DDL_T_RDAP;
      return (prev == CMD_WR) ? `DDL_T_WTR : `DDL_T_CCD;
    end
    CMD_WR: begin
      if (ap) return `DDL_T_WRAP;
      return (prev == CMD_RD) ? `DDL_T_RTW : `DDL_T_CCD;
    end
    default:  return 0;
  endcase
endfunction

// Burst window from the DFI cycles of the issued READs or WRITEs
function automatic bit in_window(bit is_wr, int c);
  if (is_wr) begin
    foreach (wr_dfi[i]) begin
      if (c >= wr_dfi[i] + `DDL_WR_LATENCY &&
          c < wr_dfi[i] + `DDL_WR_LATENCY + `DDL_BURST_CYCLES) return 1'b1;
    end
  end else begin
    foreach (rd_dfi[i]) begin
      if (c >= rd_dfi[i] + `DDL_RD_LATENCY &&
          c < rd_dfi[i] + `DDL_RD_LATENCY + `DDL_BURST_CYCLES) return 1'b1;
    end
  end
  return 1'b0;
endfunction

function automatic bit read_last(int c);
  foreach (rd_dfi[i]) begin
    if (c == rd_dfi[i] + `DDL_RD_LATENCY + `DDL_BURST_CYCLES - 1) return 1'b1;
  end
  return 1'b0;
endfunction

task automatic wait_ready();
  int limit;
  limit = cycle + `DDL_T_ZQINIT + READY_SLACK;
  while (!ctl_rdy_o && cycle < limit) begin
    @(posedge clock);
    #1;
  end
  expect_true(ctl_rdy_o, "ctl_rdy_o stayed low, controller could not issue");
endtask

// Ready must rise exactly on cycle due
task automatic expect_ready_at(int due);
  int seen;
  int limit;
  seen = -1;
  limit = due + READY_SLACK;
  while (seen < 0 && cycle < limit) begin
    @(posedge clock);
    #1;
    if (ctl_rdy_o) seen = cycle;
  end
  expect_true(seen >= 0, "ctl_rdy_o did not return after the command delay");
  if (seen >= 0) begin
    check_value("ready cycle", 32'(due), 32'(seen));
    check_value("ctl_run_o", 32'(1), 32'(ctl_run_o));
  end
endtask

// One legal command through the handshake, the DFI bus and its delay
task automatic issue_cmd(ddl_cmd_e cmd, bit ap);
  ddl_addr_u  adr;
  logic [2:0] ba;
  int         acc;
  int         due;
  ba = 3'($urandom);
  adr.row = `DDL_ROW_BITS'($urandom);
  if (cmd inside {CMD_RD, CMD_WR}) adr.cas.ap = ap;
  wait_ready();
  ctl_req_i = 1'b1;
  ctl_cmd_i = cmd;
  ctl_ba_i  = ba;
  ctl_adr_i = adr.row;
  @(posedge clock);
  #1;
  acc = cycle;
  ctl_req_i = 1'b0;
  ctl_cmd_i = CMD_NOOP;
  due = acc + cmd_delay(cmd, ap, last_cmd);
  last_cmd = cmd;
  if (cmd == CMD_WR) wr_dfi.push_back(acc + 1);
  if (cmd == CMD_RD) rd_dfi.push_back(acc + 1);
  check_value("ctl_rdy_o after accept", 32'(0), 32'(ctl_rdy_o));
  @(posedge clock);
  #1;
  check_value("dfi command", 32'(cmd), 32'({dfi_ras_no, dfi_cas_no, dfi_we_no}));
  check_value("dfi_bank_o", 32'(ba), 32'(dfi_bank_o));
  check_value("dfi_addr_o", 32'(adr.row), 32'(dfi_addr_o));
  check_value("ctl_rdy_o during delay", 32'(0), 32'(ctl_rdy_o));
  @(posedge clock);
  #1;
  check_value("dfi command", 32'(CMD_NOOP), 32'({dfi_ras_no, dfi_cas_no, dfi_we_no}));
  check_value("ctl_rdy_o during delay", 32'(cycle >= due), 32'(ctl_rdy_o));
  expect_ready_at(due);
endtask

// Run until every burst window, and the write enable after it, has closed
task automatic drain_windows();
  int limit;
  limit = cycle;
  if (wr_dfi.size() != 0 && wr_dfi[$] + `DDL_WR_LATENCY + `DDL_BURST_CYCLES + 1 > limit)
    limit = wr_dfi[$] + `DDL_WR_LATENCY + `DDL_BURST_CYCLES + 1;
  if (rd_dfi.size() != 0 && rd_dfi[$] + `DDL_RD_LATENCY + `DDL_BURST_CYCLES > limit)
    limit = rd_dfi[$] + `DDL_RD_LATENCY + `DDL_BURST_CYCLES;
  while (cycle < limit) begin
    @(posedge clock);
    #1;
  end
endtask

task automatic test_init();
  int due;
  test_name = "init";
  check_value("ctl_rdy_o", 32'(0), 32'(ctl_rdy_o));
  check_value("ctl_run_o", 32'(0), 32'(ctl_run_o));
  check_value("dfi command", 32'(CMD_NOOP), 32'({dfi_ras_no, dfi_cas_no, dfi_we_no}));
  ddr_cke_i = 1'b1;
  // The next edge is the first one that sees cke high
  due = cycle + 1 + `DDL_T_INIT;
  expect_ready_at(due);
endtask

task automatic test_init_sequence();
  test_name = "init_sequence";
  issue_cmd(CMD_MRS, 1'b0);
  issue_cmd(CMD_MRS, 1'b0);
  issue_cmd(CMD_ZQCL, 1'b0);
  issue_cmd(CMD_REF, 1'b0);
endtask

task automatic test_write_path();
  test_name = "write_path";
  issue_cmd(CMD_ACT, 1'b0);
  issue_cmd(CMD_WR, 1'b0);
  issue_cmd(CMD_WR, 1'b0);
  drain_windows();
endtask

task automatic test_read_path();
  test_name = "read_path";
  issue_cmd(CMD_RD, 1'b0);
  issue_cmd(CMD_RD, 1'b1);
  drain_windows();
endtask

// After the auto-precharge the bank sequence is idle, where READ is illegal
task automatic test_illegal_cmd();
  ddl_addr_u adr;
  test_name = "illegal_cmd";
  wait_ready();
  adr.row = `DDL_ROW_BITS'($urandom);
  adr.cas.ap = 1'b0;
  ctl_req_i = 1'b1;
  ctl_cmd_i = CMD_RD;
  ctl_ba_i  = 3'($urandom);
  ctl_adr_i = adr.row;
  repeat (2) begin
    @(posedge clock);
    #1;
    check_value("ctl_rdy_o", 32'(1), 32'(ctl_rdy_o));
    check_value("dfi command", 32'(CMD_NOOP), 32'({dfi_ras_no, dfi_cas_no, dfi_we_no}));
  end
  ctl_req_i = 1'b0;
  ctl_cmd_i = CMD_NOOP;
  @(posedge clock);
  #1;
  check_value("dfi command", 32'(CMD_NOOP), 32'({dfi_ras_no, dfi_cas_no, dfi_we_no}));
  drain_windows();
endtask

`endif

// File: bench/tb_ddr3_ddl.sv
`timescale 1ns/1ns
`default_nettype none

`include "ddl_cfg.svh"

module tb_ddr3_ddl;
  import ddl_pkg::*;

  localparam logic [31:0] SEED = 32'h3085_586c;
  localparam int READY_SLACK = 16;

  // Sum of all command delays in the test sequence
  localparam int TEST_CYCLES = 3 + `DDL_T_INIT + 2 * `DDL_T_MRD + `DDL_T_ZQINIT +
                               `DDL_T_RFC + `DDL_T_RCD + 2 * `DDL_T_CCD +
                               `DDL_T_WTR + `DDL_T_RDAP;
  localparam int WATCHDOG_CYCLES = TEST_CYCLES + 100;

  logic                       clock;
  logic                       reset;
  logic                       ddr_cke_i;
  logic                       ctl_run_o;
  logic                       ctl_rdy_o;
  logic                       ctl_req_i;
  ddl_cmd_e                   ctl_cmd_i;
  logic [2:0]                 ctl_ba_i;
  logic [`DDL_ROW_BITS-1:0]   ctl_adr_i;
  logic                       mem_wvalid_i;
  logic                       mem_wlast_i;
  logic                       mem_wready_o;
  logic [`DDL_MASK_WIDTH-1:0] mem_wrmask_i;
  logic [`DDL_DATA_WIDTH-1:0] mem_wrdata_i;
  logic                       mem_rvalid_o;
  logic                       mem_rlast_o;
  logic [`DDL_DATA_WIDTH-1:0] mem_rddata_o;
  logic                       dfi_ras_no;
  logic                       dfi_cas_no;
  logic                       dfi_we_no;
  logic [2:0]                 dfi_bank_o;
  logic [`DDL_ROW_BITS-1:0]   dfi_addr_o;
  logic                       dfi_wstb_o;
  logic                       dfi_wren_o;
  logic [`DDL_MASK_WIDTH-1:0] dfi_mask_o;
  logic [`DDL_DATA_WIDTH-1:0] dfi_data_o;
  logic                       dfi_rden_o;
  logic                       dfi_rvld_i;
  logic [`DDL_DATA_WIDTH-1:0] dfi_data_i;

  int       cycle = 0;
  int       errors = 0;
  int       checks = 0;
  string    test_name = "reset";
  ddl_cmd_e last_cmd = CMD_NOOP;

  // DFI cycles of the WRITEs and READs issued so far
  int wr_dfi[$];
  int rd_dfi[$];

  ddr3_ddl_top DUT (
    .clock        (clock),
    .reset        (reset),
    .ddr_cke_i    (ddr_cke_i),
    .ctl_run_o    (ctl_run_o),
    .ctl_rdy_o    (ctl_rdy_o),
    .ctl_req_i    (ctl_req_i),
    .ctl_cmd_i    (ctl_cmd_i),
    .ctl_ba_i     (ctl_ba_i),
    .ctl_adr_i    (ctl_adr_i),
    .mem_wvalid_i (mem_wvalid_i),
    .mem_wlast_i  (mem_wlast_i),
    .mem_wready_o (mem_wready_o),
    .mem_wrmask_i (mem_wrmask_i),
    .mem_wrdata_i (mem_wrdata_i),
    .mem_rvalid_o (mem_rvalid_o),
    .mem_rlast_o  (mem_rlast_o),
    .mem_rddata_o (mem_rddata_o),
    .dfi_ras_no   (dfi_ras_no),
    .dfi_cas_no   (dfi_cas_no),
    .dfi_we_no    (dfi_we_no),
    .dfi_bank_o   (dfi_bank_o),
    .dfi_addr_o   (dfi_addr_o),
    .dfi_wstb_o   (dfi_wstb_o),
    .dfi_wren_o   (dfi_wren_o),
    .dfi_mask_o   (dfi_mask_o),
    .dfi_data_o   (dfi_data_o),
    .dfi_rden_o   (dfi_rden_o),
    .dfi_rvld_i   (dfi_rvld_i),
    .dfi_data_i   (dfi_data_i)
  );

  `include "tb_ddl_tasks.svh"

  // Window checks each cycle, then random data through both paths
  task automatic watch_data_path();
    logic [`DDL_DATA_WIDTH-1:0] wdata;
    logic [`DDL_DATA_WIDTH-1:0] rdata;
    logic [`DDL_MASK_WIDTH-1:0] wmask;
    logic                       rvld;
    forever begin
      @(posedge clock);
      #1;
      check_value("dfi_wstb_o", 32'(in_window(1'b1, cycle)), 32'(dfi_wstb_o));
      check_value("dfi_wren_o", 32'(in_window(1'b1, cycle - 1)), 32'(dfi_wren_o));
      check_value("mem_wready_o", 32'(in_window(1'b1, cycle - 1)), 32'(mem_wready_o));
      check_value("dfi_rden_o", 32'(in_window(1'b0, cycle)), 32'(dfi_rden_o));
      check_value("mem_rlast_o", 32'(read_last(cycle)), 32'(mem_rlast_o));
      wdata = `DDL_DATA_WIDTH'($urandom);
      rdata = `DDL_DATA_WIDTH'($urandom);
      wmask = `DDL_MASK_WIDTH'($urandom);
      rvld  = 1'($urandom);
      mem_wrdata_i = wdata;
      mem_wrmask_i = wmask;
      dfi_data_i   = rdata;
      dfi_rvld_i   = rvld;
      #4;
      check_value("dfi_data_o", 32'(wdata), 32'(dfi_data_o));
      check_value("dfi_mask_o", 32'(wmask), 32'(dfi_mask_o));
      check_value("mem_rddata_o", 32'(rdata), 32'(mem_rddata_o));
      check_value("mem_rvalid_o", 32'(rvld), 32'(mem_rvalid_o));
    end
  endtask

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  always @(posedge clock) begin
    cycle <= cycle + 1;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clock);
    $display("Watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
    $display("SOME TESTS FAILED");
    $finish;
  end

  initial begin
    void'($urandom(SEED));
    reset        = 1'b1;
    ddr_cke_i    = 1'b0;
    ctl_req_i    = 1'b0;
    ctl_cmd_i    = CMD_NOOP;
    ctl_ba_i     = '0;
    ctl_adr_i    = '0;
    mem_wvalid_i = 1'b0;
    mem_wlast_i  = 1'b0;
    mem_wrmask_i = '0;
    mem_wrdata_i = '0;
    dfi_rvld_i   = 1'b0;
    dfi_data_i   = '0;
    repeat (3) @(posedge clock);
    #1;
    reset = 1'b0;
    fork
      watch_data_path();
    join_none
    test_init();
    test_init_sequence();
    test_write_path();
    test_read_path();
    test_illegal_cmd();
    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: hdl/ddl_burst_window.sv
`timescale 1ns/1ns
`default_nettype none

`include "ddl_cfg.svh"

module ddl_burst_window #(
  parameter int LATENCY = 3
) (
  input  logic clock,
  input  logic reset,
  input  logic start_i,
  output logic window_o,
  output logic last_o
);

  localparam int CNT_BITS = $clog2(`DDL_BURST_CYCLES);

  logic [LATENCY-1:0]  pipe_q;
  logic [CNT_BITS-1:0] count_q;
  logic                tap_w;

  // Start pulse after LATENCY cycles; opens the first window cycle
  assign tap_w = pipe_q[LATENCY-1];

  always_ff @(posedge clock) begin
    if (reset) begin
      pipe_q  <= '0;
      count_q <= '0;
    end else begin
      pipe_q[0] <= start_i;
      for (int i = 1; i < LATENCY; i++) begin
        pipe_q[i] <= pipe_q[i-1];
      end
      // Remaining burst cycles after the tap cycle
      if (tap_w) begin
        count_q <= CNT_BITS'(`DDL_BURST_CYCLES - 1);
      end else if (count_q != '0) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  assign window_o = tap_w || (count_q != '0);
  assign last_o   = !tap_w && (count_q == CNT_BITS'(1));

  // A new burst may only begin in the last cycle of the one before
  a_no_overrun: assert property (
    @(posedge clock) disable iff (reset) tap_w |-> count_q <= CNT_BITS'(1)
  );

endmodule

`default_nettype wire

// File: hdl/ddl_cfg.svh
`ifndef DDL_CFG_SVH
`define DDL_CFG_SVH

// Address widths
`define DDL_ROW_BITS 13
`define DDL_COL_BITS 10

// DFI data path
`define DDL_DATA_WIDTH 32
`define DDL_MASK_WIDTH 4

// BL8 takes four clock cycles on the DFI side
`define DDL_BURST_CYCLES 4

// From READ/WRITE on the DFI bus to the start of the burst window
`define DDL_WR_LATENCY 3
`define DDL_RD_LATENCY 4

// DDR3 timing, in cycles from the accepting edge to ready again
`define DDL_T_INIT 4
`define DDL_T_MRD 4
`define DDL_T_RP 3
`define DDL_T_RFC 11
`define DDL_T_ZQINIT 64
`define DDL_T_RCD 3
`define DDL_T_CCD 4
`define DDL_T_RTW 6
`define DDL_T_WTR 10
`define DDL_T_RDAP 8
`define DDL_T_WRAP 14

// Wide enough for the longest delay above
`define DDL_TIMER_BITS 7

`endif

// File: hdl/ddl_cmd_fsm.sv
`timescale 1ns/1ns
`default_nettype none

`include "ddl_cfg.svh"

module ddl_cmd_fsm (
  input  logic                    clock,
  input  logic                    reset,
  input  logic                    ddr_cke_i,
  input  logic                    ctl_req_i,
  input  ddl_pkg::ddl_cmd_e       ctl_cmd_i,
  input  logic [2:0]              ctl_ba_i,
  input  ddl_pkg::ddl_addr_u      ctl_adr_i,
  output logic                    ctl_rdy_o,
  output logic                    ctl_run_o,
  ddl_issue_if.fsm                iss
);
  import ddl_pkg::*;

  localparam int TW = `DDL_TIMER_BITS;

  // The first edge with cke high already counts down, hence the extra cycle
  localparam logic [TW-1:0] DLY_INIT   = TW'(`DDL_T_INIT + 1);
  localparam logic [TW-1:0] DLY_MRD    = TW'(`DDL_T_MRD);
  localparam logic [TW-1:0] DLY_RP     = TW'(`DDL_T_RP);
  localparam logic [TW-1:0] DLY_RFC    = TW'(`DDL_T_RFC);
  localparam logic [TW-1:0] DLY_ZQINIT = TW'(`DDL_T_ZQINIT);
  localparam logic [TW-1:0] DLY_RCD    = TW'(`DDL_T_RCD);
  localparam logic [TW-1:0] DLY_CCD    = TW'(`DDL_T_CCD);
  localparam logic [TW-1:0] DLY_RTW    = TW'(`DDL_T_RTW);
  localparam logic [TW-1:0] DLY_WTR    = TW'(`DDL_T_WTR);
  localparam logic [TW-1:0] DLY_RDAP   = TW'(`DDL_T_RDAP);
  localparam logic [TW-1:0] DLY_WRAP   = TW'(`DDL_T_WRAP);

  ddl_state_e  state_q;
  ddl_state_e  next_w;
  logic [TW-1:0] timer_q;
  logic [TW-1:0] delay_w;
  logic        legal_w;
  logic        take_w;
  logic        rdy_q;
  logic        run_q;
  logic        valid_q;
  ddl_cmd_e    cmd_q;
  logic [2:0]  bank_q;
  ddl_addr_u   addr_q;

  // Commands that each state may be followed by
  always_comb begin
    case (state_q)
      ST_IDLE: legal_w = ctl_cmd_i inside {CMD_ACT, CMD_PRE, CMD_REF, CMD_MRS, CMD_ZQCL};
      ST_ACTV,
      ST_READ,
      ST_WRIT: legal_w = ctl_cmd_i inside {CMD_RD, CMD_WR, CMD_ACT};
      ST_PREC: legal_w = ctl_cmd_i inside {CMD_ACT, CMD_REF};
      ST_REFR: legal_w = ctl_cmd_i inside {CMD_ACT, CMD_REF};
      ST_MODE: legal_w = ctl_cmd_i inside {CMD_MRS, CMD_REF, CMD_PRE, CMD_ZQCL};
      ST_ZQCL: legal_w = ctl_cmd_i inside {CMD_ACT, CMD_REF, CMD_PRE};
      default: legal_w = 1'b0;
    endcase
  end

  // Target state and hold-off delay of the requested command
  always_comb begin
    next_w  = state_q;
    delay_w = '0;
    case (ctl_cmd_i)
      CMD_ACT: begin
        next_w  = ST_ACTV;
        delay_w = DLY_RCD;
      end
      CMD_PRE: begin
        next_w  = ST_PREC;
        delay_w = DLY_RP;
      end
      CMD_REF: begin
        next_w  = ST_REFR;
        delay_w = DLY_RFC;
      end
      CMD_MRS: begin
        next_w  = ST_MODE;
        delay_w = DLY_MRD;
      end
      CMD_ZQCL: begin
        next_w  = ST_ZQCL;
        delay_w = DLY_ZQINIT;
      end
      CMD_RD: begin
        if (ctl_adr_i.cas.ap) begin
          next_w  = ST_IDLE;
          delay_w = DLY_RDAP;
        end else begin
          next_w  = ST_READ;
          delay_w = (state_q == ST_WRIT) ? DLY_WTR : DLY_CCD;
        end
      end
      CMD_WR: begin
        if (ctl_adr_i.cas.ap) begin
          next_w  = ST_IDLE;
          delay_w = DLY_WRAP;
        end else begin
          next_w  = ST_WRIT;
          delay_w = (state_q == ST_READ) ? DLY_RTW : DLY_CCD;
        end
      end
      default: begin
        next_w  = state_q;
        delay_w = '0;
      end
    endcase
  end

  // Illegal requests and NOOP fall through here and are dropped
  assign take_w = ctl_req_i && rdy_q && legal_w;

  always_ff @(posedge clock) begin
    if (reset || !ddr_cke_i) begin
      state_q <= ST_IDLE;
      timer_q <= DLY_INIT;
      rdy_q   <= 1'b0;
      run_q   <= 1'b0;
      valid_q <= 1'b0;
    end else begin
      valid_q <= 1'b0;
      if (timer_q != '0) begin
        timer_q <= timer_q - 1'b1;
        // Last count, ready comes back on this edge
        if (timer_q == TW'(1)) begin
          rdy_q <= 1'b1;
          run_q <= 1'b1;
        end
      end else if (take_w) begin
        state_q <= next_w;
        timer_q <= delay_w;
        rdy_q   <= 1'b0;
        valid_q <= 1'b1;
      end
    end
  end

  // Command fields for the issue stage
  always_ff @(posedge clock) begin
    if (take_w) begin
      cmd_q  <= ctl_cmd_i;
      bank_q <= ctl_ba_i;
      addr_q <= ctl_adr_i;
    end
  end

  assign ctl_rdy_o = rdy_q;
  assign ctl_run_o = run_q;

  assign iss.valid = valid_q;
  assign iss.cmd   = cmd_q;
  assign iss.bank  = bank_q;
  assign iss.addr  = addr_q;

  a_rdy_after_timer: assert property (
    @(posedge clock) disable iff (reset) ctl_rdy_o |-> timer_q == '0
  );

  a_single_issue: assert property (
    @(posedge clock) disable iff (reset) iss.valid |=> !iss.valid
  );

endmodule

`default_nettype wire

// File: hdl/ddl_issue.sv
`timescale 1ns/1ns
`default_nettype none

`include "ddl_cfg.svh"

module ddl_issue (
  input  logic                     clock,
  input  logic                     reset,
  ddl_issue_if.issue               iss,
  output logic                     dfi_ras_no,
  output logic                     dfi_cas_no,
  output logic                     dfi_we_no,
  output logic [2:0]               dfi_bank_o,
  output logic [`DDL_ROW_BITS-1:0] dfi_addr_o,
  output logic                     wr_start_o,
  output logic                     rd_start_o
);
  import ddl_pkg::*;

  ddl_cmd_e                 cmd_q;
  logic [2:0]               bank_q;
  logic [`DDL_ROW_BITS-1:0] addr_q;
  logic                     wr_start_q;
  logic                     rd_start_q;

  // One cycle on the bus, then back to NOOP
  always_ff @(posedge clock) begin
    if (reset) begin
      cmd_q      <= CMD_NOOP;
      wr_start_q <= 1'b0;
      rd_start_q <= 1'b0;
    end else begin
      cmd_q      <= iss.valid ? iss.cmd : CMD_NOOP;
      wr_start_q <= iss.valid && (iss.cmd == CMD_WR);
      rd_start_q <= iss.valid && (iss.cmd == CMD_RD);
    end
  end

  // Bank and address only matter alongside a command
  always_ff @(posedge clock) begin
    if (iss.valid) begin
      bank_q <= iss.bank;
      addr_q <= iss.addr.row;
    end
  end

  assign {dfi_ras_no, dfi_cas_no, dfi_we_no} = cmd_q;

  assign dfi_bank_o = bank_q;
  assign dfi_addr_o = addr_q;
  assign wr_start_o = wr_start_q;
  assign rd_start_o = rd_start_q;

endmodule

`default_nettype wire

// File: hdl/ddl_issue_if.sv
`timescale 1ns/1ns
`default_nettype none

// One accepted command, from the state machine to the issue stage
interface ddl_issue_if;
  import ddl_pkg::*;

  // Single-cycle pulse, never back-pressured
  logic       valid;
  ddl_cmd_e   cmd;
  logic [2:0] bank;
  ddl_addr_u  addr;

  modport fsm (
    output valid,
    output cmd,
    output bank,
    output addr
  );

  modport issue (
    input valid,
    input cmd,
    input bank,
    input addr
  );

endinterface

`default_nettype wire

// File: hdl/ddl_pkg.sv
`default_nettype none

`include "ddl_cfg.svh"

package ddl_pkg;

  // JEDEC command encoding, bits are {RAS#, CAS#, WE#}
  typedef enum logic [2:0] {
    CMD_MRS  = 3'b000,
    CMD_REF  = 3'b001,
    CMD_PRE  = 3'b010,
    CMD_ACT  = 3'b011,
    CMD_WR   = 3'b100,
    CMD_RD   = 3'b101,
    CMD_ZQCL = 3'b110,
    CMD_NOOP = 3'b111
  } ddl_cmd_e;

  // Bank-sequence states
  typedef enum logic [2:0] {
    ST_IDLE,
    ST_ACTV,
    ST_READ,
    ST_WRIT,
    ST_PREC,
    ST_REFR,
    ST_MODE,
    ST_ZQCL
  } ddl_state_e;

  // Column view of the address word, for READ, WRITE and PRECHARGE
  typedef struct packed {
    logic [`DDL_ROW_BITS-`DDL_COL_BITS-2:0] high;
    logic                                   ap;  // A10, auto-precharge or all banks
    logic [`DDL_COL_BITS-1:0]               col;
  } ddl_cas_addr_t;

  // Row view for ACTIVATE and MODE, column view otherwise
  typedef union packed {
    logic [`DDL_ROW_BITS-1:0] row;
    ddl_cas_addr_t            cas;
  } ddl_addr_u;

endpackage

`default_nettype wire

// File: hdl/ddr3_ddl_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "ddl_cfg.svh"

module ddr3_ddl_top (
  input  logic                       clock,
  input  logic                       reset,
  input  logic                       ddr_cke_i,

  // Memory controller
  output logic                       ctl_run_o,
  output logic                       ctl_rdy_o,
  input  logic                       ctl_req_i,
  input  ddl_pkg::ddl_cmd_e          ctl_cmd_i,
  input  logic [2:0]                 ctl_ba_i,
  input  logic [`DDL_ROW_BITS-1:0]   ctl_adr_i,

  // Write data path
  input  logic                       mem_wvalid_i,
  input  logic                       mem_wlast_i,
  output logic                       mem_wready_o,
  input  logic [`DDL_MASK_WIDTH-1:0] mem_wrmask_i,
  input  logic [`DDL_DATA_WIDTH-1:0] mem_wrdata_i,

  // Read data path
  output logic                       mem_rvalid_o,
  output logic                       mem_rlast_o,
  output logic [`DDL_DATA_WIDTH-1:0] mem_rddata_o,

  // DFI side
  output logic                       dfi_ras_no,
  output logic                       dfi_cas_no,
  output logic                       dfi_we_no,
  output logic [2:0]                 dfi_bank_o,
  output logic [`DDL_ROW_BITS-1:0]   dfi_addr_o,
  output logic                       dfi_wstb_o,
  output logic                       dfi_wren_o,
  output logic [`DDL_MASK_WIDTH-1:0] dfi_mask_o,
  output logic [`DDL_DATA_WIDTH-1:0] dfi_data_o,
  output logic                       dfi_rden_o,
  input  logic                       dfi_rvld_i,
  input  logic [`DDL_DATA_WIDTH-1:0] dfi_data_i
);

  logic wr_start_w;
  logic rd_start_w;
  logic wstb_w;
  logic wren_q;

  ddl_issue_if iss_bus ();

  ddl_cmd_fsm u_fsm (
    .clock     (clock),
    .reset     (reset),
    .ddr_cke_i (ddr_cke_i),
    .ctl_req_i (ctl_req_i),
    .ctl_cmd_i (ctl_cmd_i),
    .ctl_ba_i  (ctl_ba_i),
    .ctl_adr_i (ctl_adr_i),
    .ctl_rdy_o (ctl_rdy_o),
    .ctl_run_o (ctl_run_o),
    .iss       (iss_bus)
  );

  ddl_issue u_issue (
    .clock      (clock),
    .reset      (reset),
    .iss        (iss_bus),
    .dfi_ras_no (dfi_ras_no),
    .dfi_cas_no (dfi_cas_no),
    .dfi_we_no  (dfi_we_no),
    .dfi_bank_o (dfi_bank_o),
    .dfi_addr_o (dfi_addr_o),
    .wr_start_o (wr_start_w),
    .rd_start_o (rd_start_w)
  );

  // Write strobe window at CAS-write latency
  ddl_burst_window #(
    .LATENCY (`DDL_WR_LATENCY)
  ) u_wr_window (
    .clock    (clock),
    .reset    (reset),
    .start_i  (wr_start_w),
    .window_o (wstb_w),
    .last_o   ()
  );

  // Read enable window at CAS latency
  ddl_burst_window #(
    .LATENCY (`DDL_RD_LATENCY)
  ) u_rd_window (
    .clock    (clock),
    .reset    (reset),
    .start_i  (rd_start_w),
    .window_o (dfi_rden_o),
    .last_o   (mem_rlast_o)
  );

  // Write data enable trails the strobe by a cycle
  always_ff @(posedge clock) begin
    if (reset) begin
      wren_q <= 1'b0;
    end else begin
      wren_q <= wstb_w;
    end
  end

  assign dfi_wstb_o   = wstb_w;
  assign dfi_wren_o   = wren_q;
  assign mem_wready_o = wren_q;

  assign dfi_mask_o = mem_wrmask_i;
  assign dfi_data_o = mem_wrdata_i;

  // No back-pressure on reads
  assign mem_rvalid_o = dfi_rvld_i;
  assign mem_rddata_o = dfi_data_i;

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# Build and run the DDR3 data-link testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ns \
  -f sim.f --top-module tb_ddr3_ddl -o tb_ddr3_ddl > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
  cat "$BUILD_LOG"
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_ddr3_ddl > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

# The log decides the result
if grep -q "SOME TESTS FAILED" "$SIM_LOG"; then
  exit 1
fi
exit 0

// File: sim.f
+incdir+hdl
+incdir+bench
hdl/ddl_pkg.sv
hdl/ddl_issue_if.sv
hdl/ddl_cmd_fsm.sv
hdl/ddl_issue.sv
hdl/ddl_burst_window.sv
hdl/ddr3_ddl_top.sv
bench/tb_ddr3_ddl.sv
